// File: design/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and address width
`define CPU_XLEN 32

// architectural registers, x0 included
`define CPU_REG_COUNT 32

// address of the first fetch after reset
`define CPU_RESET_PC 32'h0000_0000

`endif

// File: design/cpu_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_XOR = 3'b100,
        ALU_SLL = 3'b101,
        ALU_SLT = 3'b110
    } alu_op_t;

    // immediate formats
    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_B = 2'b10,
        IMM_J = 2'b11
    } imm_src_t;

    typedef enum logic [1:0] {
        RES_ALU  = 2'b00,
        RES_LOAD = 2'b01,
        RES_LINK = 2'b10
    } result_src_t;

    typedef enum logic [1:0] {
        PC_SEQ = 2'b00,  // pc + 4
        PC_REL = 2'b01,  // pc + imm
        PC_REG = 2'b10   // rs1 + imm
    } pc_src_t;

    // anything but LD_NONE writes rd
    typedef enum logic [2:0] {
        LD_NONE  = 3'b000,
        LD_WORD  = 3'b001,
        LD_HALF  = 3'b010,
        LD_BYTE  = 3'b011,
        LD_REG   = 3'b100,  // plain register write, no load
        LD_HALFU = 3'b110,
        LD_BYTEU = 3'b111
    } load_kind_t;

    typedef enum logic [1:0] {
        ST_NONE = 2'b00,
        ST_WORD = 2'b01,
        ST_HALF = 2'b10,
        ST_BYTE = 2'b11
    } store_kind_t;

endpackage

`default_nettype wire

// File: design/ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if import cpu_pkg::*; ();

    load_kind_t  load_kind;   // also the rd write enable
    store_kind_t store_kind;
    result_src_t result_src;
    alu_op_t     alu_op;
    logic        alu_src_imm; // b operand from immediate
    imm_src_t    imm_src;
    pc_src_t     pc_src;      // branch already resolved

    modport decoder (
        output load_kind,
        output store_kind,
        output result_src,
        output alu_op,
        output alu_src_imm,
        output imm_src,
        output pc_src
    );

    modport consumer (
        input load_kind,
        input store_kind,
        input result_src,
        input alu_op,
        input alu_src_imm,
        input imm_src,
        input pc_src
    );

endinterface

`default_nettype wire

// File: design/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit import cpu_pkg::*; (
    input  word_t   instr_i,
    input  logic    zero_i,
    input  logic    reset_i,
    ctrl_if.decoder ctrl
);

    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_alt;

    assign opcode     = instr_i[6:0];
    assign funct3     = instr_i[14:12];
    assign funct7_alt = instr_i[30];  // sub vs add

    always_comb
    begin
        // inactive word, kept for reset and unknown encodings
        ctrl.load_kind   = LD_NONE;
        ctrl.store_kind  = ST_NONE;
        ctrl.result_src  = RES_ALU;
        ctrl.alu_op      = ALU_ADD;
        ctrl.alu_src_imm = 1'b0;
        ctrl.imm_src     = IMM_I;
        ctrl.pc_src      = PC_SEQ;
        if (!reset_i)
        begin
            case (opcode)
                OP_LOAD:
                begin
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.result_src  = RES_LOAD;
                    case (funct3)
                        3'b000:  ctrl.load_kind = LD_BYTE;
                        3'b001:  ctrl.load_kind = LD_HALF;
                        3'b010:  ctrl.load_kind = LD_WORD;
                        3'b100:  ctrl.load_kind = LD_BYTEU;
                        3'b101:  ctrl.load_kind = LD_HALFU;
                        default: ctrl.load_kind = LD_NONE;
                    endcase
                end
                OP_STORE:
                begin
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.imm_src     = IMM_S;
                    case (funct3)
                        3'b000:  ctrl.store_kind = ST_BYTE;
                        3'b001:  ctrl.store_kind = ST_HALF;
                        3'b010:  ctrl.store_kind = ST_WORD;
                        default: ctrl.store_kind = ST_NONE;
                    endcase
                end
                OP_REG, OP_IMM:
                begin
                    ctrl.alu_src_imm = (opcode == OP_IMM);
                    ctrl.load_kind   = LD_REG;
                    case (funct3)
                        // funct7 only matters for register add/sub
                        3'b000:  ctrl.alu_op = (opcode == OP_REG && funct7_alt) ? ALU_SUB
                                                                                 : ALU_ADD;
                        3'b001:  ctrl.alu_op = ALU_SLL;
                        3'b010:  ctrl.alu_op = ALU_SLT;
                        3'b100:  ctrl.alu_op = ALU_XOR;
                        3'b110:  ctrl.alu_op = ALU_OR;
                        3'b111:  ctrl.alu_op = ALU_AND;
                        default: ctrl.load_kind = LD_NONE;  // sltu, shifts right
                    endcase
                end
                OP_BRANCH:
                begin
                    ctrl.alu_op  = ALU_SUB;  // zero flag means equal
                    ctrl.imm_src = IMM_B;
                    case (funct3)
                        3'b000:  ctrl.pc_src = zero_i ? PC_REL : PC_SEQ;   // beq
                        3'b001:  ctrl.pc_src = !zero_i ? PC_REL : PC_SEQ;  // bne
                        default: ctrl.pc_src = PC_SEQ;
                    endcase
                end
                OP_JAL:
                begin
                    ctrl.load_kind  = LD_REG;
                    ctrl.result_src = RES_LINK;
                    ctrl.imm_src    = IMM_J;
                    ctrl.pc_src     = PC_REL;
                end
                OP_JALR:
                begin
                    ctrl.load_kind   = LD_REG;
                    ctrl.result_src  = RES_LINK;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.pc_src      = PC_REG;
                end
                default: ctrl.pc_src = PC_SEQ;  // unknown opcode runs as a no-op
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module reg_file import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  reg_addr_t rd_addr_i,
    input  logic      rd_we_i,
    input  word_t     rd_data_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o
);

    word_t regs [`CPU_REG_COUNT];

    // x0 is never written, reads are forced to zero instead
    always_ff @(posedge clk)
    begin
        if (rd_we_i && !reset_i && rd_addr_i != '0)
        begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  word_t    a_i,
    input  word_t    b_i,
    ctrl_if.consumer ctrl,
    output word_t    result_o,
    output logic     zero_o
);

    logic slt_bit;

    assign slt_bit = ($signed(a_i) < $signed(b_i));

    always_comb
    begin
        case (ctrl.alu_op)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_XOR: result_o = a_i ^ b_i;
            ALU_SLL: result_o = a_i << b_i[4:0];  // shamt is 5 bits
            ALU_SLT:
            begin
                result_o    = '0;
                result_o[0] = slt_bit;
            end
            default: result_o = '0;
        endcase
    end

    // used by branches through the decoder
    assign zero_o = (result_o == '0);

endmodule

`default_nettype wire

// File: design/imm_extend.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module imm_extend import cpu_pkg::*; (
    input  word_t    instr_i,
    ctrl_if.consumer ctrl,
    output word_t    imm_o
);

    logic sign;

    assign sign = instr_i[31];  // sign bit sits at 31 in every format

    always_comb
    begin
        case (ctrl.imm_src)
            IMM_I: imm_o = {{(`CPU_XLEN-12){sign}}, instr_i[31:20]};
            IMM_S: imm_o = {{(`CPU_XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
            IMM_B: imm_o = {{(`CPU_XLEN-13){sign}}, sign, instr_i[7],
                            instr_i[30:25], instr_i[11:8], 1'b0};
            IMM_J: imm_o = {{(`CPU_XLEN-21){sign}}, sign, instr_i[19:12],
                            instr_i[20], instr_i[30:21], 1'b0};
            default: imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module fetch_unit import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  word_t    imm_i,
    input  word_t    rs1_data_i,
    ctrl_if.consumer ctrl,
    output word_t    pc_o,
    output word_t    link_o
);

    word_t pc_q;
    word_t pc_next;
    word_t reg_target;

    assign link_o     = pc_q + 32'd4;
    assign reg_target = rs1_data_i + imm_i;

    always_comb
    begin
        case (ctrl.pc_src)
            PC_REL:  pc_next = pc_q + imm_i;
            PC_REG:  pc_next = {reg_target[`CPU_XLEN-1:1], 1'b0};  // jalr clears bit 0
            default: pc_next = link_o;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            pc_q <= `CPU_RESET_PC;
        end
        else
        begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: design/load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module load_store_unit import cpu_pkg::*; (
    input  word_t                   addr_i,
    input  word_t                   store_data_i,
    input  word_t                   mem_rdata_i,
    ctrl_if.consumer                ctrl,
    output word_t                   mem_wdata_o,
    output logic [`CPU_XLEN/8-1:0]  mem_be_o,
    output logic                    mem_we_o,
    output word_t                   load_data_o
);

    logic [7:0]  rd_byte;
    logic [15:0] rd_half;

    assign mem_we_o = (ctrl.store_kind != ST_NONE);

    // replicate the data so every lane carries it, enables pick the lane
    always_comb
    begin
        case (ctrl.store_kind)
            ST_BYTE:
            begin
                mem_wdata_o = {4{store_data_i[7:0]}};
                mem_be_o    = 4'b0001 << addr_i[1:0];
            end
            ST_HALF:
            begin
                mem_wdata_o = {2{store_data_i[15:0]}};
                mem_be_o    = addr_i[1] ? 4'b1100 : 4'b0011;
            end
            ST_WORD:
            begin
                mem_wdata_o = store_data_i;
                mem_be_o    = 4'b1111;
            end
            default:
            begin
                mem_wdata_o = store_data_i;
                mem_be_o    = 4'b0000;
            end
        endcase
    end

    assign rd_byte = mem_rdata_i[8*addr_i[1:0] +: 8];
    assign rd_half = mem_rdata_i[16*addr_i[1] +: 16];

    always_comb
    begin
        case (ctrl.load_kind)
            LD_BYTE:  load_data_o = {{(`CPU_XLEN-8){rd_byte[7]}}, rd_byte};
            LD_BYTEU: load_data_o = {{(`CPU_XLEN-8){1'b0}}, rd_byte};
            LD_HALF:  load_data_o = {{(`CPU_XLEN-16){rd_half[15]}}, rd_half};
            LD_HALFU: load_data_o = {{(`CPU_XLEN-16){1'b0}}, rd_half};
            default:  load_data_o = mem_rdata_i;  // lw, or not a load
        endcase
    end

endmodule

`default_nettype wire

// File: design/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_top import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_i,
    input  word_t                  instr_i,
    input  word_t                  dmem_rdata_i,
    output word_t                  instr_addr_o,
    output word_t                  dmem_addr_o,
    output word_t                  dmem_wdata_o,
    output logic [`CPU_XLEN/8-1:0] dmem_be_o,
    output logic                   dmem_we_o
);

    word_t pc;
    word_t link;
    word_t imm;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_b;
    word_t alu_result;
    logic  alu_zero;
    word_t load_data;
    word_t rd_data;
    logic  rd_we;

    ctrl_if i_ctrl_if ();

    control_unit i_control_unit (
        .instr_i (instr_i),
        .zero_i  (alu_zero),
        .reset_i (reset_i),
        .ctrl    (i_ctrl_if.decoder)
    );

    assign rd_we = (i_ctrl_if.load_kind != LD_NONE);

    reg_file i_reg_file (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_addr_i (instr_i[19:15]),
        .rs2_addr_i (instr_i[24:20]),
        .rd_addr_i  (instr_i[11:7]),
        .rd_we_i    (rd_we),
        .rd_data_i  (rd_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    imm_extend i_imm_extend (
        .instr_i (instr_i),
        .ctrl    (i_ctrl_if.consumer),
        .imm_o   (imm)
    );

    assign alu_b = i_ctrl_if.alu_src_imm ? imm : rs2_data;

    alu i_alu (
        .a_i      (rs1_data),
        .b_i      (alu_b),
        .ctrl     (i_ctrl_if.consumer),
        .result_o (alu_result),
        .zero_o   (alu_zero)
    );

    fetch_unit i_fetch_unit (
        .clk        (clk),
        .reset_i    (reset_i),
        .imm_i      (imm),
        .rs1_data_i (rs1_data),
        .ctrl       (i_ctrl_if.consumer),
        .pc_o       (pc),
        .link_o     (link)
    );

    load_store_unit i_load_store_unit (
        .addr_i       (alu_result),
        .store_data_i (rs2_data),
        .mem_rdata_i  (dmem_rdata_i),
        .ctrl         (i_ctrl_if.consumer),
        .mem_wdata_o  (dmem_wdata_o),
        .mem_be_o     (dmem_be_o),
        .mem_we_o     (dmem_we_o),
        .load_data_o  (load_data)
    );

    // writeback select
    always_comb
    begin
        case (i_ctrl_if.result_src)
            RES_LOAD: rd_data = load_data;
            RES_LINK: rd_data = link;  // jal and jalr
            default:  rd_data = alu_result;
        endcase
    end

    assign instr_addr_o = pc;
    assign dmem_addr_o  = alu_result;

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic reset_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;  // 20 ns period
    end

    // reset held for 5 rising edges, released on a falling edge
    initial
    begin
        reset_o = 1'b1;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

// File: tests/cpu_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_chk import cpu_pkg::*; (
    input logic                   clk,
    input logic                   reset_i,
    input word_t                  pc_i,
    input logic                   we_i,
    input logic [`CPU_XLEN/8-1:0] be_i
);

    int fail_count = 0;  // failed assertions, summed into the testbench error count

    a_no_write_in_reset: assert property (@(posedge clk) reset_i |-> !we_i)
        else
        begin
            fail_count++;
            $error("data memory write enabled during reset");
        end

    a_write_has_lanes: assert property (@(posedge clk) disable iff (reset_i)
        we_i |-> (be_i != '0))
        else
        begin
            fail_count++;
            $error("data memory write with no byte enabled");
        end

    // only word-aligned fetches in this ISA subset
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset_i) pc_i[1:0] == 2'b00)
        else
        begin
            fail_count++;
            $error("pc is not word aligned");
        end

    a_pc_after_reset: assert property (@(posedge clk) $fell(reset_i) |-> pc_i == `CPU_RESET_PC)
        else
        begin
            fail_count++;
            $error("first fetch after reset is not at the reset address");
        end

endmodule

bind cpu_top cpu_chk i_cpu_chk (
    .clk     (clk),
    .reset_i (reset_i),
    .pc_i    (instr_addr_o),
    .we_i    (dmem_we_o),
    .be_i    (dmem_be_o)
);

`default_nettype wire

// File: tests/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_tb import cpu_pkg::*; ();

    localparam int PROG_LEN       = 200;
    localparam int TIMEOUT_CYCLES = 2 * PROG_LEN + 100;  // reset and margin included
    localparam logic [31:0] NOP_INSTR    = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [31:0] FILLER_INSTR = 32'h0010_0013;  // skipped by every jump
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    logic       clk;
    logic       reset;
    word_t      instr;
    word_t      dmem_rdata;
    word_t      instr_addr;
    word_t      dmem_addr;
    word_t      dmem_wdata;
    logic [3:0] dmem_be;
    logic       dmem_we;

    logic [31:0] lfsr;
    word_t       imem [PROG_LEN];
    logic [7:0]  dmem [256];       // memory behind the DUT ports
    logic [7:0]  model_mem [256];
    word_t       model_regs [32];
    string       reg_tag [32];     // behavior that produced each register value
    word_t       model_pc;
    int          errors;
    int          executed;
    int          cycles = 0;

    tb_clock i_tb_clock (
        .clk_o   (clk),
        .reset_o (reset)
    );

    cpu_top i_cpu_top (
        .clk          (clk),
        .reset_i      (reset),
        .instr_i      (instr),
        .dmem_rdata_i (dmem_rdata),
        .instr_addr_o (instr_addr),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_be_o    (dmem_be),
        .dmem_we_o    (dmem_we)
    );

    // both memories answer combinationally
    assign instr      = (instr_addr < 4 * PROG_LEN) ? imem[instr_addr[9:2]] : NOP_INSTR;
    assign dmem_rdata = {dmem[{dmem_addr[7:2], 2'd3}], dmem[{dmem_addr[7:2], 2'd2}],
                         dmem[{dmem_addr[7:2], 2'd1}], dmem[{dmem_addr[7:2], 2'd0}]};

    always @(posedge clk)
    begin
        if (!reset && dmem_we)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (dmem_be[b])
                    dmem[{dmem_addr[7:2], 2'(b)}] <= dmem_wdata[8*b +: 8];
            end
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: program end not reached after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic word_t rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic word_t stype_word(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], OPC_STORE};  // base is always x0
    endfunction

    function automatic word_t btype_word(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t jtype_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // offset inside the 256-byte window aligned to 1 << size bytes
    function automatic logic [11:0] aligned_offset(input logic [1:0] size);
        return 12'(draw_bits(8 - int'(size)) << size);
    endfunction

    function automatic logic [2:0] alu_funct3();
        logic [2:0] f3;
        f3 = 3'(draw_bits(3));
        if (f3 == 3'b011 || f3 == 3'b101)
            f3 = 3'b000;  // sltu and right shifts are not supported
        return f3;
    endfunction

    function automatic word_t store_of(input logic [4:0] rs2);
        logic [1:0] size;
        size = 2'(draw_bits(2));
        if (size == 2'd3)
            size = 2'd2;
        return stype_word(aligned_offset(size), rs2, {1'b0, size});
    endfunction

    task automatic build_program();
        int         k;
        int         off;
        int         need;
        logic [2:0] kind;
        logic [2:0] f3;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [1:0] size;
        logic [6:0] f7;
        logic [11:0] imm;
        k = 0;
        for (int r = 1; r < 32; r++)
        begin
            imem[k] = itype_word(12'(draw_bits(12)), 5'd0, 3'b000, 5'(r), OPC_IMM);
            k++;
        end
        while (k < PROG_LEN - 1)
        begin
            kind = 3'(draw_bits(3));
            rd   = 5'(draw_bits(5));
            rs1  = 5'(draw_bits(5));
            rs2  = 5'(draw_bits(5));
            need = (kind == 3'd6) ? 1 : (kind == 3'd7) ? 3 : 2;
            if (k + need > PROG_LEN - 1)
            begin
                imem[k] = NOP_INSTR;  // pad up to the final jump
                k++;
            end
            else if (kind <= 3'd2)
            begin
                f3 = alu_funct3();
                f7 = (f3 == 3'b000 && draw_bits(1) == 32'd1) ? 7'b0100000 : 7'b0000000;
                imem[k]     = rtype_word(f7, rs2, rs1, f3, rd);
                imem[k + 1] = store_of(rd);
                k += 2;
            end
            else if (kind <= 3'd4)
            begin
                f3  = alu_funct3();
                imm = (f3 == 3'b001) ? {7'd0, 5'(draw_bits(5))} : 12'(draw_bits(12));
                imem[k]     = itype_word(imm, rs1, f3, rd, OPC_IMM);
                imem[k + 1] = store_of(rd);
                k += 2;
            end
            else if (kind == 3'd5)
            begin
                size = 2'(draw_bits(2));
                if (size == 2'd3)
                    size = 2'd2;
                f3 = {(size != 2'd2) && (draw_bits(1) == 32'd1), size};
                imem[k]     = itype_word(aligned_offset(size), 5'd0, f3, rd, OPC_LOAD);
                imem[k + 1] = store_of(rd);
                k += 2;
            end
            else if (kind == 3'd6)
            begin
                if (draw_bits(1) == 32'd1)
                    rs2 = rs1;  // forces equal operands now and then
                off = int'(draw_bits(3)) + 2;
                if (k + off > PROG_LEN - 1)
                    off = PROG_LEN - 1 - k;
                imem[k] = btype_word(13'(4 * off), rs2, rs1, {2'b00, 1'(draw_bits(1))});
                k++;
            end
            else
            begin
                imm = 12'(4 * (k + 2)) | 12'(draw_bits(1));  // bit 0 must be dropped
                if (draw_bits(1) == 32'd1)
                    imem[k] = jtype_word(21'd8, rd);
                else
                    imem[k] = itype_word(imm, 5'd0, 3'b000, rd, OPC_JALR);
                imem[k + 1] = FILLER_INSTR;
                imem[k + 2] = store_of(rd);
                k += 3;
            end
        end
        imem[PROG_LEN - 1] = jtype_word(21'd0, 5'd0);  // jal to itself
    endtask

    task automatic report_mismatch(input string name, input word_t expected,
                                   input word_t actual);
        errors++;
        $display("Fail %s: expected %h, actual %h, model pc %h", name, expected, actual,
                 model_pc);
    endtask

    task automatic execute_model(input word_t ins);
        logic [6:0] opcode;
        logic [2:0] f3;
        logic [4:0] rd;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      res;
        word_t      addr;
        word_t      next_pc;
        word_t      exp_data;
        word_t      mask;
        logic [3:0] exp_be;
        logic [7:0] byte_v;
        logic [15:0] half_v;
        logic       writes_rd;
        string      tag;
        opcode    = ins[6:0];
        f3        = ins[14:12];
        rd        = ins[11:7];
        a         = model_regs[ins[19:15]];
        b         = model_regs[ins[24:20]];
        imm_i     = {{20{ins[31]}}, ins[31:20]};
        next_pc   = model_pc + 32'd4;
        writes_rd = 1'b0;
        res       = '0;
        tag       = "arithmetic";
        if (opcode != OPC_STORE && dmem_we !== 1'b0)
            report_mismatch("store_port", 32'd0, {31'd0, dmem_we});
        case (opcode)
            OPC_OP, OPC_IMM:
            begin
                if (opcode == OPC_IMM)
                    b = imm_i;
                case (f3)
                    3'b000:  res = (opcode == OPC_OP && ins[30]) ? a - b : a + b;
                    3'b001:  res = a << b[4:0];
                    3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b100:  res = a ^ b;
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
                writes_rd = 1'b1;
            end
            OPC_LOAD:
            begin
                addr   = a + imm_i;
                byte_v = model_mem[addr[7:0]];
                half_v = {model_mem[{addr[7:1], 1'b1}], model_mem[{addr[7:1], 1'b0}]};
                case (f3)
                    3'b000:  res = {{24{byte_v[7]}}, byte_v};
                    3'b001:  res = {{16{half_v[15]}}, half_v};
                    3'b100:  res = {24'd0, byte_v};
                    3'b101:  res = {16'd0, half_v};
                    default: res = {model_mem[{addr[7:2], 2'd3}], model_mem[{addr[7:2], 2'd2}],
                                    half_v};
                endcase
                writes_rd = 1'b1;
                tag       = "load_extension";
            end
            OPC_STORE:
            begin
                addr     = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                exp_be   = '0;
                exp_data = '0;
                mask     = '0;
                // lane k belongs to the access when it falls inside the aligned unit
                for (int k = 0; k < 4; k++)
                begin
                    if ((k >> f3[1:0]) == (int'(addr[1:0]) >> f3[1:0]))
                    begin
                        exp_be[k]          = 1'b1;
                        mask[8*k +: 8]     = 8'hff;
                        exp_data[8*k +: 8] = b[8*(k % (1 << f3[1:0])) +: 8];
                        model_mem[{addr[7:2], 2'(k)}] = exp_data[8*k +: 8];
                    end
                end
                if (dmem_we !== 1'b1)
                    report_mismatch("store_port", 32'd1, {31'd0, dmem_we});
                if (dmem_addr !== addr)
                    report_mismatch("store_port", addr, dmem_addr);
                if (dmem_be !== exp_be)
                    report_mismatch("store_port", {28'd0, exp_be}, {28'd0, dmem_be});
                if ((dmem_wdata & mask) !== exp_data)
                    report_mismatch(reg_tag[ins[24:20]], exp_data, dmem_wdata & mask);
            end
            OPC_BRANCH:
            begin
                if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b))
                    next_pc = model_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                          ins[11:8], 1'b0};
            end
            OPC_JAL:
            begin
                res       = model_pc + 32'd4;
                writes_rd = 1'b1;
                tag       = "link_value";
                next_pc   = model_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                        ins[30:21], 1'b0};
            end
            OPC_JALR:
            begin
                res       = model_pc + 32'd4;
                writes_rd = 1'b1;
                tag       = "link_value";
                next_pc   = (a + imm_i) & ~32'd1;
            end
            default: writes_rd = 1'b0;
        endcase
        if (writes_rd && rd != 5'd0)
        begin
            model_regs[rd] = res;
            reg_tag[rd]    = tag;
        end
        model_pc = next_pc;
    endtask

    initial
    begin
        logic [7:0] fill;
        errors   = 0;
        executed = 0;
        lfsr     = 32'h18e5f36f;
        for (int i = 0; i < 256; i++)
        begin
            fill         = 8'(draw_bits(8));
            dmem[i]      <= fill;
            model_mem[i] = fill;
        end
        for (int i = 0; i < 32; i++)
        begin
            model_regs[i] = '0;
            reg_tag[i]    = "arithmetic";
        end
        build_program();
        model_pc = `CPU_RESET_PC;

        // outputs are sampled at the rising edge before registers update
        @(posedge clk);
        while (reset)
        begin
            if (dmem_we !== 1'b0)
                report_mismatch("reset_state", 32'd0, {31'd0, dmem_we});
            @(posedge clk);
        end
        if (instr_addr !== `CPU_RESET_PC)
            report_mismatch("reset_state", `CPU_RESET_PC, instr_addr);

        while (model_pc != 32'(4 * (PROG_LEN - 1)))
        begin
            if (instr_addr !== model_pc)
                report_mismatch("pc_trace", model_pc, instr_addr);
            execute_model(imem[model_pc[9:2]]);
            executed++;
            @(posedge clk);
        end
        if (instr_addr !== model_pc)
            report_mismatch("pc_trace", model_pc, instr_addr);

        @(negedge clk);  // bound assertions of the last edge have run by now
        errors = errors + i_cpu_top.i_cpu_chk.fail_count;

        $display("instructions checked: %0d  errors: %0d", executed, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+design
design/cpu_pkg.sv
design/ctrl_if.sv
design/control_unit.sv
design/reg_file.sv
design/alu.sv
design/imm_extend.sv
design/fetch_unit.sv
design/load_store_unit.sv
design/cpu_top.sv
tests/tb_clock.sv
tests/cpu_chk.sv
tests/cpu_tb.sv
